/* cpu_core.f */
common/cpu_pkg.sv
controller/ir_controller.sv
logic/register_file.sv
logic/operand_select.sv
logic/alu.sv
logic/cpu_core.sv
sim/tb_clock.sv
sim/tb_cpu_core.sv

/* sim/cpu_stim.txt */
# columns: test name, pc, instruction word, expected write flag, address, data (hex)
# a write flag of 0 means that address and data are not checked
movi_r1_pos        00000004 44112345 1 01 00012345
movi_r2_neg        00000008 442ffff0 1 02 fffffff0
movi_r3_pos        0000000c 44300f0f 1 03 00000f0f
movi_r4_neg        00000010 44480000 1 04 fff80000
add_r5             00000014 40508800 1 05 00012335
sub_r6             00000018 40608c01 1 06 00011436
and_r7             0000001c 40708c02 1 07 00000305
or_r8              00000020 40810c04 1 08 ffffffff
xor_r9             00000024 40909003 1 09 fff92345
sub_r10_chained    00000028 40a29801 1 0a 00000eff
addi_r11_neg_imm   0000002c 50b0c000 1 0b 0000e345
addi_r12_pos_imm   00000030 50c18100 1 0c 0000100f
ori_r13            00000034 58d1c001 1 0d 00004f0f
xori_r14           00000038 56e17fff 1 0e ffff800f
slli_r15           0000003c 40f09008 1 0f 00123450
srli_r16           00000040 41012009 1 10 00ffffff
rotri_r17          00000044 4111900b 1 11 f00000f0
rotri_r18          00000048 4120c00b 1 12 23450001
bubble_pc_zero     00000000 44100001 0 00 00000000
unknown_opcode     0000004c 7e200005 0 00 00000000
unknown_sub_op     00000050 40308805 0 00 00000000
add_r19_unchanged  00000054 41308c00 1 13 00013254
add_r20_unchanged  00000058 41410c00 1 14 00000eff

/* sim/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*; ();

  localparam stim_path = "sim/cpu_stim.txt";
  localparam int reset_timeout = 20;
  localparam int fetch_timeout = 20;
  localparam int write_timeout = 8;
  localparam int write_delay   = 2;

  // one line of the stim file
  typedef struct packed {
    logic [data_size-1:0] pc;
    logic [data_size-1:0] ir;
    writeback_t           expected;
  } stim_entry_t;

  logic                 clock;
  logic                 reset;
  logic [data_size-1:0] pc;
  logic [data_size-1:0] ir;
  logic                 fetch;
  writeback_t           wb;

  string       test_names[$];
  stim_entry_t entries[$];
  int          checks;
  int          errors;
  bit          timed_out;

  tb_clock i_clock (
    .clock (clock),
    .reset (reset)
  );

  cpu_core i_dut (
    .clock (clock),
    .reset (reset),
    .pc    (pc),
    .ir    (ir),
    .fetch (fetch),
    .wb    (wb)
  );

  task automatic check_value(input string test_name, input string what,
                             input logic [data_size-1:0] expected,
                             input logic [data_size-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          fields;
    string       line;
    string       name;
    logic [31:0] pc_value;
    logic [31:0] ir_value;
    logic [31:0] write_flag;
    logic [31:0] address;
    logic [31:0] data;
    stim_entry_t entry;

    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file %s", stim_path);
      return;
    end
    while ($fgets(line, fd) != 0) begin
      fields = $sscanf(line, "%s %h %h %h %h %h", name, pc_value, ir_value,
                       write_flag, address, data);
      if (line.getc(0) == "#" || fields <= 0) begin
        continue;
      end
      if (fields != 6) begin
        errors++;
        $display("Skipped a stimulus line that does not have six columns: %s", line);
        continue;
      end
      entry.pc               = pc_value;
      entry.ir               = ir_value;
      entry.expected.enable  = write_flag[0];
      entry.expected.address = address[addr_size-1:0];
      entry.expected.data    = data;
      test_names.push_back(name);
      entries.push_back(entry);
    end
    $fclose(fd);
    if (entries.size() == 0) begin
      errors++;
      $display("The stimulus file holds no tests");
    end
  endtask

  task automatic drive_instruction(input stim_entry_t entry);
    pc = entry.pc;
    ir = entry.ir;
  endtask

  task automatic check_reset_phase();
    int cycles;

    cycles = 0;
    while (reset && cycles < reset_timeout) begin
      check_value("reset", "fetch", 0, fetch);
      check_value("reset", "wb enable", 0, wb.enable);
      @(negedge clock);
      cycles++;
    end
    if (reset) begin
      errors++;
      timed_out = 1'b1;
      $display("Reset was still asserted after %0d cycles", reset_timeout);
    end else begin
      // reset fell one cycle earlier, so this is the second cycle
      check_value("after_reset", "first fetch", 1, fetch);
      check_value("after_reset", "wb enable", 0, wb.enable);
    end
  endtask

  task automatic wait_fetch(input string test_name);
    int cycles;

    cycles = 0;
    while (fetch !== 1'b1 && cycles < fetch_timeout) begin
      @(negedge clock);
      cycles++;
    end
    if (fetch !== 1'b1) begin
      errors++;
      timed_out = 1'b1;
      $display("Test %s saw no fetch strobe within %0d cycles", test_name, fetch_timeout);
    end
  endtask

  task automatic wait_write(input string test_name, input logic expect_write,
                            output int cycles);
    bit found;

    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < write_timeout) begin
      @(negedge clock);
      cycles++;
      // a suppressed write has no strobe, so stop at its slot
      if (wb.enable === 1'b1 || (!expect_write && cycles == write_delay)) begin
        found = 1'b1;
      end
    end
    if (!found) begin
      errors++;
      timed_out = 1'b1;
      $display("Test %s never reached its write cycle within %0d cycles",
               test_name, write_timeout);
    end
  endtask

  task automatic check_writeback(input string test_name, input stim_entry_t entry,
                                 input int cycles);
    check_value(test_name, "write cycle", write_delay, cycles);
    check_value(test_name, "wb enable", entry.expected.enable, wb.enable);
    if (entry.expected.enable) begin
      check_value(test_name, "wb address", entry.expected.address, wb.address);
      check_value(test_name, "wb data", entry.expected.data, wb.data);
    end
  endtask

  initial begin
    int          index;
    int          cycles;
    stim_entry_t entry;

    pc        = '0;
    ir        = '0;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    load_stimulus();

    if (entries.size() > 0) begin
      @(posedge clock);
      @(negedge clock);
      drive_instruction(entries[0]);
      check_reset_phase();
    end

    index = 0;
    while (!timed_out && index < entries.size()) begin
      entry = entries[index];
      if (index > 0) begin
        // falling edge of the stop cycle, just ahead of fetch
        @(negedge clock);
        drive_instruction(entry);
      end
      wait_fetch(test_names[index]);
      if (!timed_out) begin
        wait_write(test_names[index], entry.expected.enable, cycles);
      end
      if (!timed_out) begin
        check_writeback(test_names[index], entry, cycles);
      end
      index++;
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clock,
  output logic reset
);

  localparam int half_period  = 5;
  localparam int reset_cycles = 5;

  initial begin
    clock = 1'b0;
    forever begin
      #half_period clock = ~clock;
    end
  end

  // released on a falling edge, away from the DUT's sampling edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset <= 1'b0;
  end

endmodule

/* logic/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [data_size-1:0] pc,
  input  logic [data_size-1:0] ir,
  output logic                 fetch,
  output writeback_t           wb
);

  logic                 enable_reg_read;
  logic                 enable_alu_execute;
  logic                 enable_reg_write;
  decode_t              decode;
  logic [data_size-1:0] read_data1;
  logic [data_size-1:0] read_data2;
  logic [data_size-1:0] operand;
  logic [data_size-1:0] immediate;
  logic [data_size-1:0] alu_result;
  writeback_t           writeback;

  ir_controller i_controller (
    .clock              (clock),
    .reset              (reset),
    .pc                 (pc),
    .ir                 (ir),
    .enable_reg_read    (enable_reg_read),
    .enable_alu_execute (enable_alu_execute),
    .enable_reg_write   (enable_reg_write),
    .decode             (decode)
  );

  // read addresses come straight off the incoming word
  register_file i_register_file (
    .clock            (clock),
    .reset            (reset),
    .enable_reg_read  (enable_reg_read),
    .enable_reg_write (writeback.enable),
    .read_address1    (ir[19:15]),
    .read_address2    (ir[14:10]),
    .write_address    (writeback.address),
    .write_data       (writeback.data),
    .read_data1       (read_data1),
    .read_data2       (read_data2)
  );

  operand_select i_operand_select (
    .decode    (decode),
    .reg_value (read_data2),
    .operand   (operand),
    .immediate (immediate)
  );

  alu i_alu (
    .clock              (clock),
    .reset              (reset),
    .enable_alu_execute (enable_alu_execute),
    .alu_op             (decode.alu_op),
    .operand_a          (read_data1),
    .operand_b          (operand),
    .result             (alu_result)
  );

  // bubbles and unknown codes never reach the register file
  assign writeback.enable  = enable_reg_write & decode.write_valid;
  assign writeback.address = decode.write_address;
  assign writeback.data    = decode.wb_imm ? immediate : alu_result;

  assign wb    = writeback;
  assign fetch = enable_reg_read;

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 enable_alu_execute,
  input  sub_op_t              alu_op,
  input  logic [data_size-1:0] operand_a,
  input  logic [data_size-1:0] operand_b,
  output logic [data_size-1:0] result
);

  logic [4:0]             shift_amount;
  logic [2*data_size-1:0] rotate_wide;
  logic [data_size-1:0]   alu_value;

  assign shift_amount = operand_b[4:0];

  // doubled word so the shifted-out bits land back on top
  assign rotate_wide = {operand_a, operand_a} >> shift_amount;

  always_comb begin
    case (alu_op)
      sub_add: begin
        alu_value = operand_a + operand_b;
      end
      sub_sub: begin
        alu_value = operand_a - operand_b;
      end
      sub_and: begin
        alu_value = operand_a & operand_b;
      end
      sub_or: begin
        alu_value = operand_a | operand_b;
      end
      sub_xor: begin
        alu_value = operand_a ^ operand_b;
      end
      sub_slli: begin
        alu_value = operand_a << shift_amount;
      end
      sub_srli: begin
        alu_value = operand_a >> shift_amount;
      end
      sub_rotri: begin
        alu_value = rotate_wide[data_size-1:0];
      end
      default: begin
        alu_value = '0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (enable_alu_execute) begin
      result <= alu_value;
    end
  end

endmodule

/* logic/operand_select.sv */
`timescale 1ns/1ps

module operand_select import cpu_pkg::*; (
  input  decode_t              decode,
  input  logic [data_size-1:0] reg_value,
  output logic [data_size-1:0] operand,
  output logic [data_size-1:0] immediate
);

  logic [19:0] raw;

  assign raw = decode.imm_field;

  always_comb begin
    case (decode.imm_kind)
      imm5_ze: begin
        immediate = {{(data_size - 5){1'b0}}, raw[14:10]};
      end
      imm15_se: begin
        immediate = {{(data_size - 15){raw[14]}}, raw[14:0]};
      end
      imm15_ze: begin
        immediate = {{(data_size - 15){1'b0}}, raw[14:0]};
      end
      default: begin
        immediate = {{(data_size - 20){raw[19]}}, raw};
      end
    endcase
  end

  // second alu operand
  assign operand = decode.use_imm ? immediate : reg_value;

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 enable_reg_read,
  input  logic                 enable_reg_write,
  input  logic [addr_size-1:0] read_address1,
  input  logic [addr_size-1:0] read_address2,
  input  logic [addr_size-1:0] write_address,
  input  logic [data_size-1:0] write_data,
  output logic [data_size-1:0] read_data1,
  output logic [data_size-1:0] read_data2
);

  logic [data_size-1:0] registers [reg_count];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        registers[i] <= '0;
      end
    end else if (enable_reg_write) begin
      registers[write_address] <= write_data;
    end
  end

  // both ports sampled together in the fetch phase
  always_ff @(posedge clock) begin
    if (enable_reg_read) begin
      read_data1 <= registers[read_address1];
      read_data2 <= registers[read_address2];
    end
  end

endmodule

/* controller/ir_controller.sv */
`timescale 1ns/1ps

module ir_controller import cpu_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [data_size-1:0] pc,
  input  logic [data_size-1:0] ir,
  output logic                 enable_reg_read,
  output logic                 enable_alu_execute,
  output logic                 enable_reg_write,
  output decode_t              decode
);

  state_t               state;
  state_t               next_state;
  logic [data_size-1:0] instruction;
  opcode_t              opcode;
  sub_op_t              sub_op;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_stop;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      st_stop:  next_state = st_fetch;
      st_fetch: next_state = st_exe;
      st_exe:   next_state = st_write;
      default:  next_state = st_stop;
    endcase
  end

  // one strobe per phase
  assign enable_reg_read    = (state == st_fetch);
  assign enable_alu_execute = (state == st_exe);
  assign enable_reg_write   = (state == st_write);

  // pc of zero loads a bubble
  always_ff @(posedge clock) begin
    if (reset) begin
      instruction <= '0;
    end else if (enable_reg_read) begin
      instruction <= (pc == '0) ? '0 : ir;
    end
  end

  assign opcode = opcode_t'(instruction[30:25]);
  assign sub_op = sub_op_t'(instruction[4:0]);

  always_comb begin
    decode               = '0;
    decode.write_address = instruction[24:20];
    decode.imm_field     = instruction[19:0];
    decode.alu_op        = sub_add;
    decode.imm_kind      = imm5_ze;
    decode.write_valid   = 1'b1;

    case (opcode)
      op_alu: begin
        decode.alu_op = sub_op;
        case (sub_op)
          sub_slli, sub_srli, sub_rotri: begin
            // shift amount comes from imm5
            decode.use_imm = 1'b1;
          end
          sub_add, sub_sub, sub_and, sub_xor, sub_or: begin
            decode.use_imm = 1'b0;
          end
          default: begin
            decode.write_valid = 1'b0;
          end
        endcase
      end
      op_addi: begin
        decode.alu_op   = sub_add;
        decode.imm_kind = imm15_se;
        decode.use_imm  = 1'b1;
      end
      op_ori: begin
        decode.alu_op   = sub_or;
        decode.imm_kind = imm15_ze;
        decode.use_imm  = 1'b1;
      end
      op_xori: begin
        decode.alu_op   = sub_xor;
        decode.imm_kind = imm15_ze;
        decode.use_imm  = 1'b1;
      end
      op_movi: begin
        // result bypasses the alu
        decode.imm_kind = imm20_se;
        decode.use_imm  = 1'b1;
        decode.wb_imm   = 1'b1;
      end
      default: begin
        // also covers the all-zero bubble
        decode.write_valid = 1'b0;
      end
    endcase
  end

endmodule

/* common/cpu_pkg.sv */
package cpu_pkg;

  // core sizes
  localparam int data_size = 32;
  localparam int addr_size = 5;
  localparam int reg_count = 32;

  // controller phase, one instruction per pass
  typedef enum logic [1:0] {
    st_stop  = 2'b00,
    st_fetch = 2'b01,
    st_exe   = 2'b10,
    st_write = 2'b11
  } state_t;

  // instruction bits 30 to 25
  typedef enum logic [5:0] {
    op_alu  = 6'b100000,
    op_addi = 6'b101000,
    op_ori  = 6'b101100,
    op_xori = 6'b101011,
    op_movi = 6'b100010
  } opcode_t;

  // instruction bits 4 to 0, only meaningful for op_alu
  typedef enum logic [4:0] {
    sub_add   = 5'd0,
    sub_sub   = 5'd1,
    sub_and   = 5'd2,
    sub_xor   = 5'd3,
    sub_or    = 5'd4,
    sub_slli  = 5'd8,
    sub_srli  = 5'd9,
    sub_rotri = 5'd11
  } sub_op_t;

  // how the raw immediate field is widened
  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } imm_kind_t;

  // decoded view of the latched instruction
  typedef struct packed {
    sub_op_t              alu_op;
    imm_kind_t            imm_kind;
    logic                 use_imm;
    logic                 wb_imm;
    logic                 write_valid;
    logic [addr_size-1:0] write_address;
    logic [19:0]          imm_field;
  } decode_t;

  // write-back as seen from outside the core
  typedef struct packed {
    logic                 enable;
    logic [addr_size-1:0] address;
    logic [data_size-1:0] data;
  } writeback_t;

endpackage
